/* build.f */
source/sobelPkg.sv
source/streamPkg.sv
source/windowSequencer.sv
source/partialSumCell.sv
source/gradientCombiner.sv
source/sobelEdgeTop.sv
verification/clockGen.sv
verification/edgeChecker.sv
verification/sobelTb.sv

/* run.sh */
#!/bin/sh
# Compile the Sobel testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert --top-module sobelTb -f build.f -o sobelSim \
    > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sobelSim > sim.log 2>&1 || echo "Simulator exited with an error"

# Verdict comes from the log only
grep -qx "PASS: all tests" sim.log && { echo "Simulation passed"; exit 0; }
echo "Simulation failed, see sim.log"
exit 1

/* source/gradientCombiner.sv */
`timescale 1ns/1ns

module gradientCombiner (
    input  logic                 camClock,
    input  logic                 rst,
    input  streamPkg::windowCtlT windowCtl,
    input  sobelPkg::gradPairT   cellSums [sobelPkg::cellCount],
    input  sobelPkg::magT        threshold,
    output logic                 edgeBit,
    output logic                 edgeValid,
    output streamPkg::edgeWordT  edgeWord,
    output logic                 wordValid
);

    // Absolute value, widened to the magnitude type
    function automatic sobelPkg::magT absMag(input sobelPkg::gradT value);
        logic [15:0] positive;
        positive = value[15] ? -value : value;
        return {1'b0, positive};
    endfunction

    // Cell whose window closes at this pixel
    logic [sobelPkg::cellCount-1:0] cellSelect;

    sobelPkg::gradPairT selectedPair;
    sobelPkg::magT magnitude;
    logic nextBit;

    // Bits already packed in this line's current word
    logic [$clog2(streamPkg::wordBits)-1:0] bitCount;

    // Cell (a,b) completes when row is a+2 and column is b+2, mod 3
    for (genvar i = 0; i < sobelPkg::cellCount; i++) begin : gSelect
        localparam int rowHit = (i / sobelPkg::kernelTaps + 2) % sobelPkg::kernelTaps;
        localparam int colHit = (i % sobelPkg::kernelTaps + 2) % sobelPkg::kernelTaps;
        assign cellSelect[i] = windowCtl.rowPhase[rowHit] && windowCtl.colPhase[colHit];
    end

    // AND-OR mux over the nine cells
    always_comb begin
        selectedPair = '0;
        for (int i = 0; i < sobelPkg::cellCount; i++) begin
            if (cellSelect[i]) begin
                selectedPair = selectedPair | cellSums[i];
            end
        end
    end

    assign magnitude = absMag(selectedPair.gradX) + absMag(selectedPair.gradY);

    // Windows reaching outside the frame never report an edge
    assign nextBit = (magnitude > threshold) && windowCtl.windowComplete;

    always_ff @(posedge camClock) begin
        if (rst) begin
            edgeValid <= 1'b0;
        end else begin
            edgeValid <= windowCtl.pixelValid;
        end
    end

    // Edge bit and word shifter, newest bit in LSB
    always_ff @(posedge camClock) begin
        if (windowCtl.pixelValid) begin
            edgeBit <= nextBit;
            edgeWord <= {edgeWord[streamPkg::wordBits-2:0], nextBit};
        end
    end

    // Word strobe on every 32nd bit, partial words dropped at line start
    always_ff @(posedge camClock) begin
        if (rst || windowCtl.lineStart) begin
            bitCount <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= windowCtl.pixelValid && (&bitCount);
            if (windowCtl.pixelValid) begin
                bitCount <= bitCount + 1'b1;
            end
        end
    end

    // Phases from the sequencer pick exactly one completed window
    singleCell: assert property (@(posedge camClock) disable iff (rst)
        edgeValid |-> $past($onehot(cellSelect)));

endmodule

/* source/partialSumCell.sv */
`timescale 1ns/1ns

module partialSumCell #(
    // Top row phase of the windows this cell accumulates
    parameter int rowIndex = 0,
    // Left column phase of the windows this cell accumulates
    parameter int colIndex = 0
) (
    input  logic                 camClock,
    input  logic                 rst,
    input  streamPkg::windowCtlT windowCtl,
    output sobelPkg::gradPairT   partialSum
);

    // Position of a one-hot phase relative to this cell's origin
    function automatic logic [1:0] phaseOffset(
        input streamPkg::phaseT phase,
        input int origin
    );
        int position;
        position = phase[2] ? 2 : (phase[1] ? 1 : 0);
        return 2'((position - origin + sobelPkg::kernelTaps) % sobelPkg::kernelTaps);
    endfunction

    // Line memory, one pair per window start column
    sobelPkg::gradPairT lineMem [streamPkg::cellDepth];

    streamPkg::cellAddrT cellAddr;
    sobelPkg::gradPairT storedPair;

    // Offsets of this pixel inside the cell's current window
    logic [1:0] dx;
    logic [1:0] dy;

    // First pixel of a new window
    logic restart;

    sobelPkg::gradT contribX;
    sobelPkg::gradT contribY;

    assign dx = phaseOffset(windowCtl.colPhase, colIndex);
    assign dy = phaseOffset(windowCtl.rowPhase, rowIndex);
    assign restart = (dx == 2'd0) && (dy == 2'd0);

    assign storedPair = lineMem[cellAddr];

    // Kernel tap for this pixel
    always_comb begin
        int sample;
        int xScale;
        int yScale;
        sample = int'(windowCtl.pixel);
        // Middle row doubles Gx, middle column doubles Gy
        xScale = (int'(dy) == sobelPkg::centreOffset) ? sobelPkg::centreGain
                                                      : sobelPkg::edgeGain;
        yScale = (int'(dx) == sobelPkg::centreOffset) ? sobelPkg::centreGain
                                                      : sobelPkg::edgeGain;
        contribX = sobelPkg::gradT'(sample * sobelPkg::xColWeight[dx] * xScale);
        contribY = sobelPkg::gradT'(sample * sobelPkg::yRowWeight[dy] * yScale);
    end

    // Stored sum plus this tap, or the tap alone on a fresh window
    always_comb begin
        if (restart) begin
            partialSum.gradX = contribX;
            partialSum.gradY = contribY;
        end else begin
            partialSum.gradX = storedPair.gradX + contribX;
            partialSum.gradY = storedPair.gradY + contribY;
        end
    end

    // Write back on the same edge that takes the pixel
    always_ff @(posedge camClock) begin
        if (windowCtl.pixelValid) begin
            lineMem[cellAddr] <= partialSum;
        end
    end

    // Next window slot once the right column has passed
    always_ff @(posedge camClock) begin
        if (rst || windowCtl.lineStart) begin
            cellAddr <= '0;
        end else if (windowCtl.pixelValid && dx == 2'd2) begin
            cellAddr <= cellAddr + 1'b1;
        end
    end

    // Every access lands inside the line memory
    addrInRange: assert property (@(posedge camClock) disable iff (rst)
        windowCtl.pixelValid |-> cellAddr < streamPkg::cellAddrT'(streamPkg::cellDepth));

endmodule

/* source/sobelEdgeTop.sv */
`timescale 1ns/1ns

module sobelEdgeTop (
    input  logic                camClock,
    input  logic                rst,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                pixelValid,
    input  sobelPkg::pixelT     camData,
    input  sobelPkg::magT       threshold,
    output logic                edgeBit,
    output logic                edgeValid,
    output streamPkg::edgeWordT edgeWord,
    output logic                wordValid
);

    // Shared window control, one cycle behind the ports
    streamPkg::windowCtlT windowCtl;

    // One pair per cell, index is rowIndex * 3 + colIndex
    sobelPkg::gradPairT cellSums [sobelPkg::cellCount];

    windowSequencer u_sequencer (
        .camClock   (camClock),
        .rst        (rst),
        .hsync      (hsync),
        .vsync      (vsync),
        .pixelValid (pixelValid),
        .camData    (camData),
        .windowCtl  (windowCtl)
    );

    // Every combination of top-row and left-column phase
    for (genvar r = 0; r < sobelPkg::kernelTaps; r++) begin : gRow
        for (genvar c = 0; c < sobelPkg::kernelTaps; c++) begin : gCol
            partialSumCell #(
                .rowIndex (r),
                .colIndex (c)
            ) u_cell (
                .camClock   (camClock),
                .rst        (rst),
                .windowCtl  (windowCtl),
                .partialSum (cellSums[r * sobelPkg::kernelTaps + c])
            );
        end
    end

    gradientCombiner u_combiner (
        .camClock  (camClock),
        .rst       (rst),
        .windowCtl (windowCtl),
        .cellSums  (cellSums),
        .threshold (threshold),
        .edgeBit   (edgeBit),
        .edgeValid (edgeValid),
        .edgeWord  (edgeWord),
        .wordValid (wordValid)
    );

endmodule

/* source/sobelPkg.sv */
package sobelPkg;

    // Raw camera sample
    typedef logic [7:0] pixelT;

    // Signed gradient
    // Partial and full window sums share this width
    typedef logic signed [15:0] gradT;

    // X and Y gradient kept side by side through the cells
    typedef struct packed {
        gradT gradX;
        gradT gradY;
    } gradPairT;

    // Sum of both absolute gradients, one spare bit against overflow
    typedef logic [16:0] magT;

    // Window geometry
    localparam int kernelTaps = 3;
    localparam int cellCount = kernelTaps * kernelTaps;

    // Gx sign per column offset, left column first
    localparam int xColWeight [kernelTaps] = '{-1, 0, 1};

    // Gy sign per row offset, top row first
    localparam int yRowWeight [kernelTaps] = '{1, 0, -1};

    // Offset of the middle row or column inside the window
    localparam int centreOffset = 1;

    // Middle row or column counts twice
    localparam int centreGain = 2;
    localparam int edgeGain = 1;

endpackage

/* source/streamPkg.sv */
package streamPkg;

    // One-hot position mod 3, bit k set means index mod 3 is k
    typedef logic [2:0] phaseT;

    // Phase of row 0 and column 0
    localparam phaseT phaseZero = 3'b001;

    // Column position inside a line
    typedef logic [9:0] columnT;

    // Longest line the cell memories can hold
    localparam int lineWidthMax = 640;

    // One entry per window start column of a given phase
    localparam int cellDepth = (lineWidthMax + sobelPkg::kernelTaps - 1) / sobelPkg::kernelTaps;

    typedef logic [7:0] cellAddrT;

    // Broadcast from the sequencer to every cell and the combiner
    typedef struct packed {
        sobelPkg::pixelT pixel;
        logic pixelValid;
        // Phases of this pixel, before the update it causes
        phaseT rowPhase;
        phaseT colPhase;
        // hsync or vsync seen
        logic lineStart;
        // Window ending here lies fully inside the frame
        logic windowComplete;
    } windowCtlT;

    // Edge bits per packed output word
    localparam int wordBits = 32;

    typedef logic [wordBits-1:0] edgeWordT;

endpackage

/* source/windowSequencer.sv */
`timescale 1ns/1ns

module windowSequencer (
    input  logic                 camClock,
    input  logic                 rst,
    input  logic                 hsync,
    input  logic                 vsync,
    input  logic                 pixelValid,
    input  sobelPkg::pixelT      camData,
    output streamPkg::windowCtlT windowCtl
);

    // Current row and column, mod 3
    streamPkg::phaseT rowPhase;
    streamPkg::phaseT colPhase;

    // Pixels seen so far in this line
    streamPkg::columnT column;

    // Rows completed in this frame, saturates at 2
    logic [1:0] rowCount;

    logic windowComplete;
    logic lineStart;

    assign lineStart = hsync || vsync;

    // Need two full rows and two full columns before this pixel
    assign windowComplete = (rowCount == 2'd2) && (column >= streamPkg::columnT'(2));

    // Column phase steps per pixel, restarts at every line or frame
    always_ff @(posedge camClock) begin
        if (rst || lineStart) begin
            colPhase <= streamPkg::phaseZero;
            column <= '0;
        end else if (pixelValid) begin
            colPhase <= {colPhase[1:0], colPhase[2]};
            column <= column + 1'b1;
        end
    end

    // Row phase steps on hsync only
    always_ff @(posedge camClock) begin
        if (rst || vsync) begin
            rowPhase <= streamPkg::phaseZero;
            rowCount <= '0;
        end else if (hsync) begin
            rowPhase <= {rowPhase[1:0], rowPhase[2]};
            if (rowCount != 2'd2) begin
                rowCount <= rowCount + 1'b1;
            end
        end
    end

    // Registered broadcast, phases taken before this pixel's update
    always_ff @(posedge camClock) begin
        if (rst) begin
            windowCtl <= '0;
        end else begin
            windowCtl.pixel <= camData;
            windowCtl.pixelValid <= pixelValid;
            windowCtl.rowPhase <= rowPhase;
            windowCtl.colPhase <= colPhase;
            windowCtl.lineStart <= lineStart;
            windowCtl.windowComplete <= windowComplete;
        end
    end

    // Cells decode offsets from these, so they must stay one-hot
    phaseOneHot: assert property (@(posedge camClock) disable iff (rst)
        $onehot(rowPhase) && $onehot(colPhase));

    // Sync pulses never share a cycle with a pixel
    syncApart: assert property (@(posedge camClock) disable iff (rst)
        pixelValid |-> !(hsync || vsync));

    // Lines longer than the cell memories would alias
    lineFits: assert property (@(posedge camClock) disable iff (rst)
        pixelValid |-> column < streamPkg::columnT'(streamPkg::lineWidthMax));

endmodule

/* verification/clockGen.sv */
`timescale 1ns/1ns

module clockGen #(
    parameter int halfPeriod = 20,
    parameter int resetCycles = 4
) (
    output logic camClock,
    output logic rst
);

    // Free-running camera clock
    initial begin
        camClock = 1'b0;
        forever #halfPeriod camClock = ~camClock;
    end

    // Reset seen by the DUT on the first rising edges only
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge camClock);
        rst <= 1'b0;
    end

endmodule

/* verification/edgeChecker.sv */
`timescale 1ns/1ns

module edgeChecker (
    input  logic                camClock,
    input  logic                rst,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                pixelValid,
    input  sobelPkg::pixelT     camData,
    input  sobelPkg::magT       threshold,
    input  logic                edgeBit,
    input  logic                edgeValid,
    input  streamPkg::edgeWordT edgeWord,
    input  logic                wordValid,
    input  logic                testEnd,
    output int                  checkCount,
    output int                  errorCount
);

    localparam int maxRows = 8;
    localparam int maxCols = 64;

    // Image as it entered the DUT
    int image [maxRows][maxCols];

    // Position of the next incoming pixel
    int row;
    int col;

    // Expected word of the current line
    streamPkg::edgeWordT lineWord;
    int lineBits;

    // Results the DUT still owes
    logic expBits [$];
    streamPkg::edgeWordT expWords [$];

    // pixelValid delayed by two cycles
    logic [1:0] validHist;

    function automatic int absVal(input int value);
        return (value < 0) ? -value : value;
    endfunction

    // Window with bottom-right pixel at (r,c)
    function automatic logic refEdge(input int r, input int c, input int thr);
        int gx;
        int gy;
        if (r < 2 || c < 2) begin
            return 1'b0;
        end
        // Right column minus left column, middle row doubled
        gx = image[r-2][c] + 2 * image[r-1][c] + image[r][c]
           - image[r-2][c-2] - 2 * image[r-1][c-2] - image[r][c-2];
        // Top row minus bottom row, middle column doubled
        gy = image[r-2][c-2] + 2 * image[r-2][c-1] + image[r-2][c]
           - image[r][c-2] - 2 * image[r][c-1] - image[r][c];
        return (absVal(gx) + absVal(gy)) > thr;
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("MISMATCH at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    initial begin
        checkCount = 0;
        errorCount = 0;
    end

    always @(posedge camClock) begin : compare
        logic expBit;
        streamPkg::edgeWordT expWord;
        if (rst) begin
            row = 0;
            col = 0;
            lineBits = 0;
            lineWord = '0;
            validHist = '0;
            expBits.delete();
            expWords.delete();
        end else begin
            // Two cycles from pixel to edge
            checkCount++;
            if (edgeValid !== validHist[1]) begin
                reportMismatch("edgeValid", 32'(validHist[1]), 32'(edgeValid));
            end
            if (edgeValid) begin
                if (expBits.size() == 0) begin
                    reportFailure("edgeValid high with no pixel outstanding");
                end else begin
                    expBit = expBits.pop_front();
                    checkCount++;
                    if (edgeBit !== expBit) begin
                        reportMismatch("edgeBit", 32'(expBit), 32'(edgeBit));
                    end
                end
            end
            if (wordValid) begin
                if (expWords.size() == 0) begin
                    reportFailure("wordValid high with no full word expected");
                end else begin
                    expWord = expWords.pop_front();
                    checkCount++;
                    if (edgeWord !== expWord) begin
                        reportMismatch("edgeWord", expWord, edgeWord);
                    end
                end
            end
            validHist = {validHist[0], pixelValid};
            // Frame and line position
            if (vsync) begin
                row = 0;
                col = 0;
                lineBits = 0;
            end else if (hsync) begin
                row++;
                col = 0;
                lineBits = 0;
            end
            if (pixelValid) begin
                if (row < maxRows && col < maxCols) begin
                    image[row][col] = int'(camData);
                    expBit = refEdge(row, col, int'(threshold));
                end else begin
                    reportFailure("pixel falls outside the reference image");
                    expBit = 1'b0;
                end
                expBits.push_back(expBit);
                // Newest bit enters at the LSB
                lineWord = {lineWord[streamPkg::wordBits-2:0], expBit};
                lineBits++;
                if (lineBits == streamPkg::wordBits) begin
                    expWords.push_back(lineWord);
                    lineBits = 0;
                end
                col++;
            end
            // Everything sent must have come back by now
            if (testEnd) begin
                if (expBits.size() != 0 || expWords.size() != 0) begin
                    reportFailure($sformatf("%0d edge bits and %0d words never came out",
                                            expBits.size(), expWords.size()));
                end
                expBits.delete();
                expWords.delete();
            end
        end
    end

endmodule

/* verification/sobelTb.sv */
`timescale 1ns/1ns

module sobelTb;

    localparam int clockPeriod = 40;
    localparam int maxGap = 2;
    localparam int wideCols = 64;
    localparam int narrowCols = 40;
    localparam int flatRows = 6;
    localparam int stepRows = 6;
    localparam int randomRows = 8;
    localparam int randomFrames = 2;
    localparam int wordRows = 4;

    // Run length bound
    localparam int totalPixels = wideCols * (flatRows + stepRows + randomFrames * randomRows
                                 + wordRows) + narrowCols * wordRows;
    localparam int totalSyncs = flatRows + stepRows + randomFrames * randomRows
                                + 2 * wordRows + 6;
    // Reset, idle test, drains and threshold changes
    localparam int fixedIdle = 80;
    localparam int watchdogCycles = totalPixels + totalPixels * maxGap + totalSyncs
                                    + fixedIdle + 100;

    // Pixel patterns
    localparam int patFlat = 0;
    localparam int patStep = 1;
    localparam int patRandom = 2;

    logic camClock;
    logic rst;
    logic hsync;
    logic vsync;
    logic pixelValid;
    sobelPkg::pixelT camData;
    sobelPkg::magT threshold;
    logic edgeBit;
    logic edgeValid;
    logic wordValid;
    streamPkg::edgeWordT edgeWord;

    logic testEnd;
    int checkCount;
    int errorCount;

    int seed;
    int testNumber;
    int checksBefore;
    int errorsBefore;
    int failedTests;

    clockGen #(
        .halfPeriod  (clockPeriod / 2),
        .resetCycles (4)
    ) u_clock (
        .camClock (camClock),
        .rst      (rst)
    );

    sobelEdgeTop u_dut (
        .camClock   (camClock),
        .rst        (rst),
        .hsync      (hsync),
        .vsync      (vsync),
        .pixelValid (pixelValid),
        .camData    (camData),
        .threshold  (threshold),
        .edgeBit    (edgeBit),
        .edgeValid  (edgeValid),
        .edgeWord   (edgeWord),
        .wordValid  (wordValid)
    );

    edgeChecker u_checker (
        .camClock   (camClock),
        .rst        (rst),
        .hsync      (hsync),
        .vsync      (vsync),
        .pixelValid (pixelValid),
        .camData    (camData),
        .threshold  (threshold),
        .edgeBit    (edgeBit),
        .edgeValid  (edgeValid),
        .edgeWord   (edgeWord),
        .wordValid  (wordValid),
        .testEnd    (testEnd),
        .checkCount (checkCount),
        .errorCount (errorCount)
    );

    task automatic driveIdle(input int cycles);
        repeat (cycles) begin
            @(negedge camClock);
            pixelValid = 1'b0;
            hsync = 1'b0;
            vsync = 1'b0;
        end
    endtask

    // Random gap, then one pixel cycle
    task automatic drivePixel(input sobelPkg::pixelT value);
        driveIdle($unsigned($random(seed)) % (maxGap + 1));
        @(negedge camClock);
        pixelValid = 1'b1;
        hsync = 1'b0;
        vsync = 1'b0;
        camData = value;
    endtask

    task automatic endLine();
        @(negedge camClock);
        pixelValid = 1'b0;
        hsync = 1'b1;
        vsync = 1'b0;
    endtask

    task automatic startFrame();
        @(negedge camClock);
        pixelValid = 1'b0;
        hsync = 1'b0;
        vsync = 1'b1;
    endtask

    task automatic sendFrame(input int rows, input int cols, input int pattern);
        int value;
        startFrame();
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                case (pattern)
                    patFlat: value = 90;
                    // Dark left half, bright right half
                    patStep: value = (c < cols / 2) ? 0 : 200;
                    default: value = $unsigned($random(seed)) % 256;
                endcase
                drivePixel(sobelPkg::pixelT'(value));
            end
            endLine();
        end
    endtask

    // Drain the pipeline, flush the checker, report this test
    task automatic finishTest(input string name);
        string status;
        driveIdle(4);
        @(negedge camClock);
        testEnd = 1'b1;
        @(negedge camClock);
        testEnd = 1'b0;
        testNumber++;
        status = "passed";
        if (errorCount != errorsBefore) begin
            status = "failed";
            failedTests++;
        end
        $display("Test %0d %s: %0d checks, %0d errors, %s", testNumber, name,
                 checkCount - checksBefore, errorCount - errorsBefore, status);
        checksBefore = checkCount;
        errorsBefore = errorCount;
    endtask

    initial begin
        seed = 59;
        hsync = 1'b0;
        vsync = 1'b0;
        pixelValid = 1'b0;
        camData = '0;
        threshold = '0;
        testEnd = 1'b0;
        testNumber = 0;
        checksBefore = 0;
        errorsBefore = 0;
        failedTests = 0;
        // First falling edge lies inside reset
        @(negedge camClock);
        while (rst) @(negedge camClock);

        // Outputs stay quiet without pixels
        driveIdle(10);
        finishTest("idle after reset");

        // Zero threshold is the hardest case for a flat image
        threshold = '0;
        sendFrame(flatRows, wideCols, patFlat);
        finishTest("flat image");

        threshold = sobelPkg::magT'(100);
        sendFrame(stepRows, wideCols, patStep);
        finishTest("vertical step edge");

        // New threshold per frame once the last pixel has cleared the combiner
        for (int f = 0; f < randomFrames; f++) begin
            driveIdle(2);
            threshold = sobelPkg::magT'($unsigned($random(seed)) % 800);
            sendFrame(randomRows, wideCols, patRandom);
        end
        finishTest("random frames");

        // Two words per wide line and one per narrow line
        driveIdle(2);
        threshold = sobelPkg::magT'(300);
        sendFrame(wordRows, wideCols, patRandom);
        sendFrame(wordRows, narrowCols, patRandom);
        finishTest("word packing");

        $display("Totals: %0d tests, %0d failed, %0d checks, %0d errors",
                 testNumber, failedTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdogCycles) @(posedge camClock);
        $display("Timeout: tests did not finish within %0d cycles", watchdogCycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
